/* rtl/mipsPkg.sv */
package mipsPkg;

   // primary opcode field, instr[31:26]
   typedef enum logic [5:0] {
      opRType = 6'h00,
      opJ     = 6'h02,
      opJal   = 6'h03,
      opBeq   = 6'h04,
      opBne   = 6'h05,
      opAddiu = 6'h09,
      opAndi  = 6'h0C,
      opOri   = 6'h0D,
      opLui   = 6'h0F,
      opLb    = 6'h20,
      opLh    = 6'h21,
      opLw    = 6'h23,
      opLbu   = 6'h24,
      opLhu   = 6'h25,
      opSb    = 6'h28,
      opSw    = 6'h2B
   } opcodeT;

   // R-type function field, instr[5:0]
   typedef enum logic [5:0] {
      fnSll  = 6'h00,
      fnJr   = 6'h08,
      fnAddu = 6'h21,
      fnSubu = 6'h23,
      fnAnd  = 6'h24,
      fnOr   = 6'h25,
      fnXor  = 6'h26,
      fnSlt  = 6'h2A
   } functT;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluSll, aluLui
   } aluOpT;

   typedef enum logic [1:0] {srcReg, srcImmSigned, srcImmZero, srcPc8} srcBSelT;
   typedef enum logic {fwdReg, fwdWb} fwdSelT;
   typedef enum logic [1:0] {pcPlus4, pcBranch, pcJump, pcReg} pcSelT;
   typedef enum logic [1:0] {wbAlu, wbMem, wbIo} wbSelT;

   // byte port, status word is {outValid, inValid} in bits 1:0
   localparam logic [31:0] ioDataAddr = 32'h0000FF00;
   localparam logic [31:0] ioStatAddr = 32'h0000FF04;

endpackage

/* rtl/regFile.sv */
`timescale 1ns/1ps

module regFile (
   input  logic        CLK,
   input  logic        rstN,
   input  logic        we,
   input  logic [4:0]  ra1,
   input  logic [4:0]  ra2,
   input  logic [4:0]  wa,
   input  logic [31:0] wd,
   output logic [31:0] rd1,
   output logic [31:0] rd2
);

   logic [31:0] regs [32];

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 32; i++) regs[i] <= 32'd0;
      end else if (we && wa != 5'd0) begin
         regs[wa] <= wd;
      end
   end

   // $0 always reads zero
   assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
   assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule

/* rtl/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit import mipsPkg::*; #(
   parameter int imemWords = 1024
) (
   input  logic                         CLK,
   input  logic                         rstN,
   input  pcSelT                        pcSel,
   input  logic                         flush,
   input  logic [31:0]                  branchTarget,
   input  logic [31:0]                  regTarget,
   input  logic                         progWe,
   input  logic [$clog2(imemWords)-1:0] progAddr,
   input  logic [31:0]                  progData,
   output logic [31:0]                  instr,
   output logic [31:0]                  pcPlus4
);

   localparam int aw = $clog2(imemWords);

   logic [31:0] imem [imemWords];
   logic [31:0] pc, nextPc, fetchPlus4, jumpTarget, imemData;
   logic        squash;

   assign fetchPlus4 = pc + 32'd4;
   assign jumpTarget = {pcPlus4[31:28], instr[25:0], 2'b00}; // region of stage-2 PC

   always_comb begin
      case (pcSel)
         pcBranch: nextPc = branchTarget;
         pcJump:   nextPc = jumpTarget;
         pcReg:    nextPc = regTarget;
         default:  nextPc = fetchPlus4;
      endcase
   end

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         pc     <= 32'd0;
         squash <= 1'b1; // pipeline starts with a nop
      end else begin
         pc     <= nextPc;
         squash <= flush; // kill the slot behind a taken branch
      end
   end

   always_ff @(posedge CLK) begin
      if (progWe) imem[progAddr] <= progData;
      imemData <= imem[pc[aw+1:2]];
      pcPlus4  <= fetchPlus4;
   end

   assign instr = squash ? 32'd0 : imemData;

endmodule

/* rtl/coreControl.sv */
`timescale 1ns/1ps

module coreControl import mipsPkg::*; (
   input  logic [31:0] instr,
   input  logic [31:0] aluOut,
   input  logic        takeBranch,
   input  logic [4:0]  wbDst,
   input  logic        wbWe,
   output aluOpT       aluOp,
   output srcBSelT     srcBSel,
   output fwdSelT      fwdA,
   output fwdSelT      fwdB,
   output pcSelT       pcSel,
   output logic        flush,
   output logic [4:0]  regDst,
   output logic        regWe,
   output opcodeT      memOp,
   output logic        memWe,
   output logic        ioRd,
   output logic        ioWr,
   output wbSelT       wbSel
);

   opcodeT     opcode;
   functT      funct;
   logic [4:0] rs, rt, rd;
   logic       isLoad, isStore, isIo;

   assign opcode = opcodeT'(instr[31:26]);
   assign funct  = functT'(instr[5:0]);
   assign rs     = instr[25:21];
   assign rt     = instr[20:16];
   assign rd     = instr[15:11];

   always_comb begin
      aluOp   = aluAdd;
      srcBSel = srcReg;
      pcSel   = pcPlus4;
      flush   = 1'b0;
      regDst  = rt; // i-type default
      regWe   = 1'b0;
      isLoad  = 1'b0;
      isStore = 1'b0;
      case (opcode)
         opRType: begin
            regDst = rd;
            regWe  = 1'b1;
            case (funct)
               fnAddu: aluOp = aluAdd;
               fnSubu: aluOp = aluSub;
               fnAnd:  aluOp = aluAnd;
               fnOr:   aluOp = aluOr;
               fnXor:  aluOp = aluXor;
               fnSlt:  aluOp = aluSlt;
               fnSll:  aluOp = aluSll;
               fnJr: begin
                  regWe = 1'b0;
                  pcSel = pcReg;
                  flush = 1'b1;
               end
               default: regWe = 1'b0; // unsupported funct acts as nop
            endcase
         end
         opJ: begin
            pcSel = pcJump;
            flush = 1'b1;
         end
         opJal: begin
            pcSel   = pcJump;
            flush   = 1'b1;
            srcBSel = srcPc8; // link value PC+8
            regDst  = 5'd31;
            regWe   = 1'b1;
         end
         opBeq, opBne: begin
            if (takeBranch) begin
               pcSel = pcBranch;
               flush = 1'b1;
            end
         end
         opAddiu: begin
            srcBSel = srcImmSigned;
            regWe   = 1'b1;
         end
         opAndi, opOri: begin
            aluOp   = (opcode == opAndi) ? aluAnd : aluOr;
            srcBSel = srcImmZero;
            regWe   = 1'b1;
         end
         opLui: begin
            aluOp   = aluLui;
            srcBSel = srcImmZero;
            regWe   = 1'b1;
         end
         opLb, opLh, opLw, opLbu, opLhu: begin
            srcBSel = srcImmSigned; // base + offset
            regWe   = 1'b1;
            isLoad  = 1'b1;
         end
         opSb, opSw: begin
            srcBSel = srcImmSigned;
            isStore = 1'b1;
         end
         default: ;
      endcase
      if (regDst == 5'd0) regWe = 1'b0; // $0 is never written
   end

   // stage-3 result bypass into stage 2
   assign fwdA = (wbWe && wbDst != 5'd0 && wbDst == rs) ? fwdWb : fwdReg;
   assign fwdB = (wbWe && wbDst != 5'd0 && wbDst == rt) ? fwdWb : fwdReg;

   assign isIo  = (aluOut == ioDataAddr) || (aluOut == ioStatAddr);
   assign memOp = opcode;
   assign memWe = isStore && !isIo;
   assign ioWr  = isStore && (aluOut == ioDataAddr); // stores to status are dropped
   assign ioRd  = isLoad && isIo;
   assign wbSel = !isLoad ? wbAlu : (isIo ? wbIo : wbMem);

endmodule

/* rtl/aluExec.sv */
`timescale 1ns/1ps

module aluExec import mipsPkg::*; (
   input  logic        CLK,
   input  logic        rstN,
   input  logic [31:0] rd1,
   input  logic [31:0] rd2,
   input  logic [31:0] wbData,
   input  fwdSelT      fwdA,
   input  fwdSelT      fwdB,
   input  srcBSelT     srcBSel,
   input  aluOpT       aluOp,
   input  logic [31:0] instr,
   input  logic [31:0] pcPlus4,
   input  logic [4:0]  regDst,
   input  logic        regWe,
   input  opcodeT      s2MemOp,
   input  logic        s2MemWe,
   input  logic        s2IoRd,
   input  logic        s2IoWr,
   input  wbSelT       s2WbSel,
   output logic [31:0] aluOut,
   output logic        takeBranch,
   output logic [31:0] branchTarget,
   output logic [31:0] regTarget,
   output logic [4:0]  wbDst,
   output logic        wbWe,
   output logic [31:0] memAddr,
   output logic [31:0] storeData,
   output opcodeT      memOp,
   output logic        memWe,
   output logic        ioRd,
   output logic        ioWr,
   output wbSelT       wbSel
);

   logic [31:0] rsVal, rtVal, opA, opB, immSigned, immZero;
   opcodeT      opcode;
   logic        equal;

   assign opcode    = opcodeT'(instr[31:26]);
   assign rsVal     = (fwdA == fwdWb) ? wbData : rd1;
   assign rtVal     = (fwdB == fwdWb) ? wbData : rd2;
   assign immSigned = {{16{instr[15]}}, instr[15:0]};
   assign immZero   = {16'h0000, instr[15:0]};
   assign opA       = (srcBSel == srcPc8) ? 32'd0 : rsVal; // jal passes B through the adder

   always_comb begin
      case (srcBSel)
         srcImmSigned: opB = immSigned;
         srcImmZero:   opB = immZero;
         srcPc8:       opB = pcPlus4 + 32'd4;
         default:      opB = rtVal;
      endcase
      case (aluOp)
         aluAdd:  aluOut = opA + opB;
         aluSub:  aluOut = opA - opB;
         aluAnd:  aluOut = opA & opB;
         aluOr:   aluOut = opA | opB;
         aluXor:  aluOut = opA ^ opB;
         aluSlt:  aluOut = {31'd0, $signed(opA) < $signed(opB)};
         aluSll:  aluOut = opB << instr[10:6]; // shamt
         aluLui:  aluOut = {opB[15:0], 16'h0000};
         default: aluOut = 32'd0;
      endcase
   end

   assign equal        = (rsVal == rtVal);
   assign takeBranch   = (opcode == opBeq && equal) || (opcode == opBne && !equal);
   assign branchTarget = pcPlus4 + {immSigned[29:0], 2'b00};
   assign regTarget    = rsVal; // jr target

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) begin
         wbWe  <= 1'b0;
         memWe <= 1'b0;
         ioRd  <= 1'b0;
         ioWr  <= 1'b0;
         wbSel <= wbAlu;
      end else begin
         wbWe  <= regWe;
         memWe <= s2MemWe;
         ioRd  <= s2IoRd;
         ioWr  <= s2IoWr;
         wbSel <= s2WbSel;
      end
   end

   always_ff @(posedge CLK) begin
      wbDst     <= regDst;
      memAddr   <= aluOut;
      storeData <= rtVal;
      memOp     <= s2MemOp;
   end

endmodule

/* rtl/memAccess.sv */
`timescale 1ns/1ps

module memAccess import mipsPkg::*; #(
   parameter int dmemWords = 1024
) (
   input  logic        CLK,
   input  logic        rstN,
   input  logic [31:0] memAddr,
   input  logic [31:0] storeData,
   input  opcodeT      memOp,
   input  logic        memWe,
   input  logic        ioRd,
   input  logic        ioWr,
   input  wbSelT       wbSel,
   input  logic [31:0] aluResult,
   input  logic        outReady,
   input  logic        inValid,
   input  logic [7:0]  inData,
   output logic [31:0] wbData,
   output logic        outValid,
   output logic [7:0]  outData,
   output logic        inReady
);

   localparam int aw = $clog2(dmemWords);

   logic [31:0]   dmem [dmemWords];
   logic [31:0]   rdWord, loadData, ioData, laneData;
   logic [3:0]    laneEn;
   logic [aw-1:0] wrIdx, rdIdx;
   logic [1:0]    offset;
   logic [7:0]    loadByte;
   logic [15:0]   loadHalf;

   assign wrIdx  = memAddr[aw+1:2];
   assign rdIdx  = aluResult[aw+1:2]; // read issued from stage 2
   assign offset = memAddr[1:0];

   // big-endian lanes, offset 0 is bits 31:24
   assign laneEn   = (memOp == opSb) ? (4'b1000 >> offset) : 4'b1111;
   assign laneData = (memOp == opSb) ? {4{storeData[7:0]}} : storeData;

   always_ff @(posedge CLK) begin
      for (int i = 0; i < 4; i++) begin
         if (memWe && laneEn[i]) dmem[wrIdx][8*i +: 8] <= laneData[8*i +: 8];
         // store in stage 3 bypasses a load to the same word
         if (memWe && laneEn[i] && wrIdx == rdIdx) rdWord[8*i +: 8] <= laneData[8*i +: 8];
         else rdWord[8*i +: 8] <= dmem[rdIdx][8*i +: 8];
      end
   end

   assign loadByte = rdWord[{2'd3 - offset, 3'b000} +: 8];
   assign loadHalf = offset[1] ? rdWord[15:0] : rdWord[31:16];

   always_comb begin
      case (memOp)
         opLb:    loadData = {{24{loadByte[7]}}, loadByte};
         opLbu:   loadData = {24'd0, loadByte};
         opLh:    loadData = {{16{loadHalf[15]}}, loadHalf};
         opLhu:   loadData = {16'd0, loadHalf};
         default: loadData = rdWord; // lw
      endcase
      case (wbSel)
         wbMem:   wbData = loadData;
         wbIo:    wbData = ioData;
         default: wbData = memAddr; // registered alu result
      endcase
   end

   assign ioData  = (memAddr == ioStatAddr) ? {30'd0, outValid, inValid} : {24'd0, inData};
   assign inReady = ioRd && (memAddr == ioDataAddr); // one-cycle pop

   always_ff @(posedge CLK or negedge rstN) begin
      if (!rstN) outValid <= 1'b0;
      else if (ioWr) outValid <= 1'b1;
      else if (outReady) outValid <= 1'b0; // accepted by the sink
   end

   always_ff @(posedge CLK) begin
      if (ioWr) outData <= storeData[7:0];
   end

endmodule

/* rtl/mipsLite.sv */
`timescale 1ns/1ps

module mipsLite import mipsPkg::*; #(
   parameter int imemWords = 1024,
   parameter int dmemWords = 1024
) (
   input  logic                         CLK,
   input  logic                         rstN,
   input  logic                         progWe,
   input  logic [$clog2(imemWords)-1:0] progAddr,
   input  logic [31:0]                  progData,
   input  logic                         outReady,
   input  logic                         inValid,
   input  logic [7:0]                   inData,
   output logic                         outValid,
   output logic [7:0]                   outData,
   output logic                         inReady
);

   logic [31:0] instr, s2PcPlus4, aluOut, branchTarget, regTarget;
   logic [31:0] rd1, rd2, wbData, memAddr, storeData;
   logic        takeBranch, flush, regWe, wbWe;
   logic        ctlMemWe, ctlIoRd, ctlIoWr, memWe, ioRd, ioWr;
   logic [4:0]  regDst, wbDst;
   aluOpT       aluOp;
   srcBSelT     srcBSel;
   fwdSelT      fwdA, fwdB;
   pcSelT       pcSel;
   opcodeT      ctlMemOp, memOp;
   wbSelT       ctlWbSel, wbSel;

   coreControl i_coreControl (
      .instr(instr), .aluOut(aluOut), .takeBranch(takeBranch), .wbDst(wbDst), .wbWe(wbWe),
      .aluOp(aluOp), .srcBSel(srcBSel), .fwdA(fwdA), .fwdB(fwdB), .pcSel(pcSel),
      .flush(flush), .regDst(regDst), .regWe(regWe), .memOp(ctlMemOp), .memWe(ctlMemWe),
      .ioRd(ctlIoRd), .ioWr(ctlIoWr), .wbSel(ctlWbSel));

   fetchUnit #(.imemWords(imemWords)) i_fetchUnit (
      .CLK(CLK), .rstN(rstN), .pcSel(pcSel), .flush(flush), .branchTarget(branchTarget),
      .regTarget(regTarget), .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .instr(instr), .pcPlus4(s2PcPlus4));

   regFile i_regFile (
      .CLK(CLK), .rstN(rstN), .we(wbWe), .ra1(instr[25:21]), .ra2(instr[20:16]),
      .wa(wbDst), .wd(wbData), .rd1(rd1), .rd2(rd2));

   aluExec i_aluExec (
      .CLK(CLK), .rstN(rstN), .rd1(rd1), .rd2(rd2), .wbData(wbData), .fwdA(fwdA),
      .fwdB(fwdB), .srcBSel(srcBSel), .aluOp(aluOp), .instr(instr), .pcPlus4(s2PcPlus4),
      .regDst(regDst), .regWe(regWe), .s2MemOp(ctlMemOp), .s2MemWe(ctlMemWe),
      .s2IoRd(ctlIoRd), .s2IoWr(ctlIoWr), .s2WbSel(ctlWbSel), .aluOut(aluOut),
      .takeBranch(takeBranch), .branchTarget(branchTarget), .regTarget(regTarget),
      .wbDst(wbDst), .wbWe(wbWe), .memAddr(memAddr), .storeData(storeData),
      .memOp(memOp), .memWe(memWe), .ioRd(ioRd), .ioWr(ioWr), .wbSel(wbSel));

   memAccess #(.dmemWords(dmemWords)) i_memAccess (
      .CLK(CLK), .rstN(rstN), .memAddr(memAddr), .storeData(storeData), .memOp(memOp),
      .memWe(memWe), .ioRd(ioRd), .ioWr(ioWr), .wbSel(wbSel), .aluResult(aluOut),
      .outReady(outReady), .inValid(inValid), .inData(inData), .wbData(wbData),
      .outValid(outValid), .outData(outData), .inReady(inReady));

endmodule

/* verification/mipsLite_checker.sv */
`timescale 1ns/1ps

module mipsLite_checker (
   input logic       CLK,
   input logic       rstN,
   input logic       outValid,
   input logic       outReady,
   input logic [7:0] outData,
   input logic       inValid,
   input logic       inReady
);

   // held byte must not change until the sink takes it
   outDataStable: assert property (@(posedge CLK) disable iff (!rstN)
      outValid && !outReady |=> $stable(outData))
      else $error("outData changed while outValid was waiting");

   inReadyOnValid: assert property (@(posedge CLK) disable iff (!rstN)
      inReady |-> inValid)
      else $error("inReady raised without inValid");

   outValidAfterReset: assert property (@(posedge CLK) !rstN |=> !outValid)
      else $error("outValid high right after reset");

endmodule

bind memAccess mipsLite_checker i_checker (
   .CLK(CLK), .rstN(rstN), .outValid(outValid), .outReady(outReady),
   .outData(outData), .inValid(inValid), .inReady(inReady));

/* verification/mipsLiteTb.sv */
`timescale 1ns/1ps

module mipsLiteTb import mipsPkg::*;;

   localparam int maxCycles = 40 * 400;
   localparam int pairsPerTest = 2;

   logic        CLK, rstN, progWe, outReady, inValid, inReady, outValid;
   logic [9:0]  progAddr;
   logic [31:0] progData, byteBuf;
   logic [7:0]  inData, outData;
   logic [31:0] prog[$], expQ[$];
   logic [7:0]  inQ[$];
   int          errors, checks, doneCount, outBytes, nBytes, cycles, gap, testNum;
   bit          popped;

   mipsLite #(.imemWords(1024), .dmemWords(1024)) i_mipsLite (
      .CLK(CLK), .rstN(rstN), .progWe(progWe), .progAddr(progAddr), .progData(progData),
      .outReady(outReady), .inValid(inValid), .inData(inData), .outValid(outValid),
      .outData(outData), .inReady(inReady));

   initial begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   function automatic logic [31:0] rTypeWord(functT fn, logic [4:0] rs, logic [4:0] rt,
                                              logic [4:0] rd, logic [4:0] sh);
      return {opRType, rs, rt, rd, sh, fn};
   endfunction

   function automatic logic [31:0] iTypeWord(opcodeT op, logic [4:0] rs, logic [4:0] rt,
                                              logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [31:0] jTypeWord(opcodeT op, logic [25:0] target);
      return {op, target};
   endfunction

   // expected result from the ISA rules, imm carries the offset, shamt or link address
   function automatic logic [31:0] mipsRef(opcodeT op, functT fn, logic [31:0] a,
                                           logic [31:0] b, logic [15:0] imm);
      logic [7:0]  bt;
      logic [15:0] hf;
      bt = 8'(a >> (8 * (3 - imm[1:0]))); // big-endian lane
      hf = imm[1] ? a[15:0] : a[31:16];
      case (op)
         opRType: begin
            case (fn)
               fnAddu:  return a + b;
               fnSubu:  return a - b;
               fnAnd:   return a & b;
               fnOr:    return a | b;
               fnXor:   return a ^ b;
               fnSlt:   return {31'd0, $signed(a) < $signed(b)};
               fnSll:   return b << imm[4:0];
               fnJr:    return 32'h22;
               default: return 32'd0;
            endcase
         end
         opAddiu: return a + {{16{imm[15]}}, imm};
         opAndi:  return a & {16'd0, imm};
         opOri:   return a | {16'd0, imm};
         opLui:   return {imm, 16'd0};
         opLb:    return {{24{bt[7]}}, bt};
         opLbu:   return {24'd0, bt};
         opLh:    return {{16{hf[15]}}, hf};
         opLhu:   return {16'd0, hf};
         opLw:    return a;
         opBeq:   return (a == b) ? 32'h22 : 32'h11;
         opBne:   return (a != b) ? 32'h22 : 32'h11;
         opJ:     return 32'h22;
         opJal:   return 32'h22 + {16'd0, imm};
         default: return 32'd0;
      endcase
   endfunction

   task automatic checkByte(logic [7:0] got, logic [7:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Mismatch outData got %h expected %h", got, exp);
         errors++;
      end
   endtask

   task automatic checkWord(logic [31:0] got, logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("Mismatch outData word got %h expected %h", got, exp);
         errors++;
      end
   endtask

   // sink side, outData is stable at the falling edge
   always @(negedge CLK) begin
      if (rstN && outValid && outReady) begin
         byteBuf = {byteBuf[23:0], outData};
         nBytes++;
         if (nBytes == outBytes) begin
            nBytes = 0;
            if (expQ.size() == 0) begin
               $display("output arrived with no result expected");
               errors++;
            end else if (outBytes == 1) begin
               checkByte(outData, 8'(expQ.pop_front()));
            end else begin
               checkWord(byteBuf, expQ.pop_front());
            end
            doneCount++;
         end
      end
      if (inValid && inReady) popped = 1'b1;
   end

   always @(posedge CLK) begin
      #1;
      outReady = 1'($urandom % 2);
      if (popped) begin
         inValid = 1'b0;
         popped  = 1'b0;
         gap     = $urandom % 4; // idle cycles before the next byte
      end else if (!inValid && gap > 0) begin
         gap--;
      end else if (!inValid && rstN && inQ.size() > 0) begin
         inValid = 1'b1;
         inData  = inQ.pop_front();
      end
   end

   always @(posedge CLK) begin
      cycles++;
      if (cycles >= maxCycles) begin
         $display("timeout after %0d cycles, %0d results outstanding", cycles, expQ.size());
         $display("Test failed");
         $finish;
      end
   end

   task automatic runTest(opcodeT op, functT fn, logic [15:0] imm, bit zeroTest);
      bit          isCtl;
      int          b0, errBefore;
      logic [7:0]  a, b;
      logic [15:0] link;
      isCtl = (op inside {opBeq, opBne, opJ, opJal}) || (op == opRType && fn == fnJr);
      errBefore = errors;
      prog = {};
      prog.push_back(iTypeWord(opOri, 0, 1, 16'hFF00)); // $1 = I/O base
      for (int r = 3; r <= 4; r++) begin
         prog.push_back(iTypeWord(opLw, 1, 2, 16'h0004)); // wait for inValid
         prog.push_back(iTypeWord(opAndi, 2, 2, 16'h0001));
         prog.push_back(iTypeWord(opBeq, 2, 0, 16'hFFFD));
         prog.push_back(iTypeWord(opLw, 1, 5'(r), 16'h0000));
      end
      prog.push_back(rTypeWord(fnSll, 0, 3, 7, 24)); // x = {a, 0, 0, b}
      prog.push_back(rTypeWord(fnOr, 7, 4, 7, 0));
      prog.push_back(rTypeWord(fnSll, 0, 4, 8, 16)); // y = {0, b, 0, a}
      prog.push_back(rTypeWord(fnOr, 8, 3, 8, 0));
      b0 = prog.size() + 2;
      link = 16'(b0 * 4 + 8);
      if (zeroTest) begin
         prog.push_back(rTypeWord(fnAddu, 7, 8, 0, 0));
         prog.push_back(rTypeWord(fnOr, 0, 0, 5, 0));
      end else if (isCtl) begin
         prog.push_back(rTypeWord(fnAddu, 0, 0, 5, 0)); // marker starts at zero
         prog.push_back(iTypeWord(opOri, 0, 9, 16'((b0 + 3) * 4)));
         if (op == opBeq || op == opBne) prog.push_back(iTypeWord(op, 3, 4, 16'd2));
         else if (op == opRType) prog.push_back(rTypeWord(fnJr, 9, 0, 0, 0));
         else prog.push_back(jTypeWord(op, 26'(b0 + 3)));
         prog.push_back(iTypeWord(opOri, 0, 5, 16'h0011)); // fall-through marker
         prog.push_back(jTypeWord(opJ, 26'(b0 + 5)));
         prog.push_back(iTypeWord(opOri, 5, 5, 16'h0022)); // taken marker
         prog.push_back(rTypeWord(fnAddu, 5, 31, 5, 0));
      end else if (op == opRType && fn == fnSll) begin
         prog.push_back(rTypeWord(fnSll, 0, 8, 5, imm[4:0]));
      end else if (op == opRType) begin
         prog.push_back(rTypeWord(fn, 7, 8, 5, 0));
      end else if (op inside {opLb, opLbu, opLh, opLhu, opLw}) begin
         prog.push_back(iTypeWord(opSw, 0, 7, 16'h0100));
         prog.push_back(iTypeWord(op, 0, 5, 16'h0100 + imm));
      end else begin
         prog.push_back(iTypeWord(op, 7, 5, imm));
      end
      outBytes = isCtl ? 1 : 4;
      prog.push_back(iTypeWord(opSw, 0, 5, 16'h0100));
      for (int k = 4 - outBytes; k < 4; k++) begin
         prog.push_back(iTypeWord(opLw, 1, 2, 16'h0004)); // wait while busy
         prog.push_back(iTypeWord(opAndi, 2, 2, 16'h0002));
         prog.push_back(iTypeWord(opBne, 2, 0, 16'hFFFD));
         prog.push_back(iTypeWord(opLbu, 0, 6, 16'(16'h0100 + k)));
         prog.push_back(iTypeWord(opSb, 1, 6, 16'h0000));
      end
      prog.push_back(jTypeWord(opJ, 26'd1));
      inQ = {};
      expQ = {};
      for (int p = 0; p < pairsPerTest; p++) begin
         a = 8'($urandom);
         b = !isCtl ? 8'($urandom) : ((p == 0) ? a : ~a); // both branch directions
         inQ.push_back(a);
         inQ.push_back(b);
         if (zeroTest) expQ.push_back(32'd0);
         else if (isCtl) expQ.push_back(mipsRef(op, fn, {24'd0, a}, {24'd0, b}, link));
         else expQ.push_back(mipsRef(op, fn, {a, 16'd0, b}, {8'd0, b, 8'd0, a}, imm));
      end
      doneCount = 0;
      nBytes = 0;
      rstN = 1'b0;
      for (int i = 0; i < prog.size() || i < 5; i++) begin
         progWe   = (i < prog.size());
         progAddr = 10'(i);
         progData = (i < prog.size()) ? prog[i] : 32'd0;
         @(posedge CLK);
         #1;
      end
      progWe = 1'b0;
      rstN = 1'b1;
      while (doneCount < pairsPerTest) @(posedge CLK);
      #1;
      testNum++;
      $display("test %0d %s/%s imm %h: %0d results, %0d errors", testNum, op.name(),
               fn.name(), imm, doneCount, errors - errBefore);
   endtask

   initial begin
      functT  rFns[7]   = '{fnAddu, fnSubu, fnAnd, fnOr, fnXor, fnSlt, fnSll};
      opcodeT iOps[4]   = '{opAddiu, opAndi, opOri, opLui};
      opcodeT ldOps[5]  = '{opLb, opLbu, opLh, opLhu, opLw};
      opcodeT ctlOps[4] = '{opBeq, opBne, opJ, opJal};
      int     seed;
      seed = $urandom(6);
      rstN = 1'b0;
      progWe = 1'b0;
      progAddr = '0;
      progData = '0;
      outReady = 1'b0;
      inValid = 1'b0;
      inData = '0;
      popped = 1'b0;
      gap = 0;
      errors = 0;
      checks = 0;
      cycles = 0;
      testNum = 0;
      outBytes = 4;
      byteBuf = '0;
      foreach (rFns[i]) runTest(opRType, rFns[i], 16'($urandom), 1'b0);
      foreach (iOps[i]) runTest(iOps[i], fnSll, 16'($urandom), 1'b0);
      foreach (ldOps[i]) begin
         for (int off = 0; off < 4; off += (ldOps[i] inside {opLh, opLhu}) ? 2 : 1) begin
            runTest(ldOps[i], fnSll, 16'(off), 1'b0);
            if (ldOps[i] == opLw) break;
         end
      end
      foreach (ctlOps[i]) runTest(ctlOps[i], fnSll, 16'd0, 1'b0);
      runTest(opRType, fnJr, 16'd0, 1'b0);
      runTest(opRType, fnAddu, 16'd0, 1'b1); // $0 write then readback
      $display("%0d tests, %0d checks, %0d errors, %0d cycles", testNum, checks, errors, cycles);
      if (errors == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

/* mipsLite.f */
rtl/mipsPkg.sv
rtl/regFile.sv
rtl/fetchUnit.sv
rtl/coreControl.sv
rtl/aluExec.sv
rtl/memAccess.sv
rtl/mipsLite.sv
verification/mipsLite_checker.sv
verification/mipsLiteTb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= mipsLiteTb
FLIST     ?= mipsLite.f
PASS_MSG  := Test completed successfully

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
